/* hdl/i2c_pkg.sv */
`default_nettype none

package i2c_pkg;

    // one bus condition per command
    typedef enum logic [1:0] {
        CMD_START = 2'd0,
        CMD_STOP  = 2'd1,
        CMD_WRITE = 2'd2,   // drive wbit for one SCL period
        CMD_READ  = 2'd3    // release SDA and sample
    } bit_cmd_t;

    localparam int BYTE_BITS = 8;

    // byte as it moves on the wire, MSB first
    typedef logic [BYTE_BITS-1:0] byte_t;

endpackage

`default_nettype wire

/* hdl/eeprom_pkg.sv */
`default_nettype none

package eeprom_pkg;

    localparam int ADDR_BITS  = 11;
    localparam int DATA_BITS  = 8;
    localparam int BLOCK_BITS = 3;                       // carried in the control byte
    localparam int WORD_BITS  = ADDR_BITS - BLOCK_BITS;  // carried in the address byte

    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    typedef logic [ADDR_BITS-1:0]  mem_addr_t;
    typedef logic [DATA_BITS-1:0]  mem_data_t;
    typedef logic [BLOCK_BITS-1:0] block_t;
    typedef logic [WORD_BITS-1:0]  word_addr_t;

    function automatic block_t addr_block(mem_addr_t addr);
        return addr[ADDR_BITS-1 -: BLOCK_BITS];
    endfunction

    function automatic word_addr_t addr_word(mem_addr_t addr);
        return addr[WORD_BITS-1:0];
    endfunction

endpackage

`default_nettype wire

/* hdl/i2c_bit_if.sv */
`default_nettype none

interface i2c_bit_if;

    import i2c_pkg::*;

    bit_cmd_t cmd;
    logic     cmd_valid;
    logic     cmd_ready;   // low for the whole bus activity of a command
    logic     wbit;        // SDA level for a write bit
    logic     rbit;        // SDA sampled during SCL high
    logic     rbit_valid;  // one cycle, end of a data bit

    modport seq (
        output cmd,
        output cmd_valid,
        output wbit,
        input  cmd_ready,
        input  rbit,
        input  rbit_valid
    );

    modport eng (
        input  cmd,
        input  cmd_valid,
        input  wbit,
        output cmd_ready,
        output rbit,
        output rbit_valid
    );

endinterface

`default_nettype wire

/* hdl/i2c_bit_engine.sv */
`default_nettype none

module i2c_bit_engine #(
    parameter int SCL_DIV = 4
) (
    input  logic   CLK,
    input  logic   RESET,
    output logic   scl,
    output logic   sda_drive_low,
    input  logic   sda_in,
    i2c_bit_if.eng bit_bus
);

    import i2c_pkg::*;

    localparam int CNT_W = $clog2(SCL_DIV);

    logic             busy;
    logic [1:0]       phase;      // quarter of the SCL period
    logic [CNT_W-1:0] qcnt;
    logic             phase_end;
    logic             is_data;
    bit_cmd_t         cmd_q;
    logic             wbit_q;

    // {scl, sda_drive_low} for a command entering phase p
    function automatic logic [1:0] bus_level(
        bit_cmd_t   c,
        logic [1:0] p,
        logic       wb,
        logic       scl_now,
        logic       low_now
    );
        logic [1:0] lvl;
        case (c)
            CMD_START: begin
                case (p)
                    2'd0:    lvl = {scl_now, 1'b0};   // release SDA first
                    2'd1:    lvl = 2'b10;
                    default: lvl = 2'b11;             // SDA falls with SCL high
                endcase
            end
            CMD_STOP: begin
                case (p)
                    2'd0:    lvl = 2'b01;
                    2'd1:    lvl = 2'b11;
                    default: lvl = 2'b10;             // SDA rises with SCL high
                endcase
            end
            default: begin
                case (p)
                    2'd0:    lvl = {1'b0, low_now};
                    2'd1:    lvl = {1'b0, (c == CMD_WRITE) ? !wb : 1'b0};
                    default: lvl = {1'b1, low_now};
                endcase
            end
        endcase
        return lvl;
    endfunction

    assign phase_end         = (qcnt == CNT_W'(SCL_DIV - 1));
    assign is_data           = (cmd_q == CMD_WRITE) || (cmd_q == CMD_READ);
    assign bit_bus.cmd_ready = !busy;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy               <= 1'b0;
            phase              <= 2'd0;
            qcnt               <= '0;
            cmd_q              <= CMD_STOP;
            scl                <= 1'b1;
            sda_drive_low      <= 1'b0;
            bit_bus.rbit_valid <= 1'b0;
        end else begin
            bit_bus.rbit_valid <= 1'b0;
            if (!busy) begin
                if (bit_bus.cmd_valid) begin
                    busy  <= 1'b1;
                    cmd_q <= bit_bus.cmd;
                    phase <= 2'd0;
                    qcnt  <= '0;
                    {scl, sda_drive_low} <= bus_level(bit_bus.cmd, 2'd0, bit_bus.wbit,
                                                      scl, sda_drive_low);
                end
            end else if (!phase_end) begin
                qcnt <= qcnt + 1'b1;
            end else begin
                qcnt <= '0;
                if (phase == 2'd3) begin
                    busy <= 1'b0;
                    if (is_data) begin
                        scl                <= 1'b0;  // data bits end with SCL low
                        bit_bus.rbit_valid <= 1'b1;
                    end
                end else begin
                    phase <= phase + 2'd1;
                    {scl, sda_drive_low} <= bus_level(cmd_q, phase + 2'd1, wbit_q,
                                                      scl, sda_drive_low);
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!busy && bit_bus.cmd_valid) begin
            wbit_q <= bit_bus.wbit;
        end
        // middle of the SCL high time
        if (busy && is_data && phase == 2'd2 && phase_end) begin
            bit_bus.rbit <= sda_in;
        end
    end

    a_sda_stable_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && $changed(sda_drive_low)) |->
            (cmd_q == CMD_START || cmd_q == CMD_STOP));

    // command length is fixed at four quarters
    a_cmd_length: assert property (@(posedge CLK) disable iff (RESET)
        (bit_bus.cmd_valid && bit_bus.cmd_ready) |=>
            !bit_bus.cmd_ready ##(4*SCL_DIV - 1) (!bit_bus.cmd_ready ##1 bit_bus.cmd_ready));

endmodule

`default_nettype wire

/* hdl/eeprom_sequencer.sv */
`default_nettype none

module eeprom_sequencer (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  logic                 req_write,
    input  eeprom_pkg::mem_addr_t req_addr,
    input  eeprom_pkg::mem_data_t req_wdata,
    output logic                 rsp_valid,
    output eeprom_pkg::mem_data_t rsp_rdata,
    output logic                 rsp_nack,
    i2c_bit_if.seq               bit_bus
);

    import i2c_pkg::*;
    import eeprom_pkg::*;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_CTRL,     // control byte, write direction
        ST_ADDR,
        ST_WDATA,
        ST_RSTART,
        ST_RCTRL,    // control byte, read direction
        ST_RDATA,
        ST_MACK,
        ST_STOP
    } state_t;

    state_t    st;
    logic      wait_q;     // holding off commands until a result is back
    logic [3:0] bit_cnt;   // 8 bits plus ack slot
    byte_t     shreg;
    logic      wr_q;
    mem_addr_t addr_q;
    mem_data_t wdata_q;
    mem_data_t rdata_q;
    logic      nack_q;
    logic      fire;
    logic      ack_done;
    logic      byte_state;

    function automatic byte_t ctrl_byte(mem_addr_t addr, logic rd);
        return {DEVICE_CODE, addr_block(addr), rd};
    endfunction

    assign req_ready         = (st == ST_IDLE);
    assign byte_state        = st inside {ST_CTRL, ST_ADDR, ST_WDATA, ST_RCTRL};
    assign bit_bus.cmd_valid = (st != ST_IDLE) && !wait_q;
    assign fire              = bit_bus.cmd_valid && bit_bus.cmd_ready;
    assign ack_done          = wait_q && bit_bus.rbit_valid;
    assign bit_bus.wbit      = (st == ST_MACK) ? 1'b1 : shreg[7];  // NACK after the data byte
    assign rsp_rdata         = rdata_q;
    assign rsp_nack          = nack_q;

    always_comb begin
        case (st)
            ST_START, ST_RSTART: bit_bus.cmd = CMD_START;
            ST_STOP:             bit_bus.cmd = CMD_STOP;
            ST_RDATA:            bit_bus.cmd = CMD_READ;
            ST_MACK:             bit_bus.cmd = CMD_WRITE;
            default:             bit_bus.cmd = (bit_cnt == 4'd8) ? CMD_READ : CMD_WRITE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            st        <= ST_IDLE;
            wait_q    <= 1'b0;
            bit_cnt   <= 4'd0;
            nack_q    <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (st)
                ST_IDLE: begin
                    if (req_valid) begin
                        st     <= ST_START;
                        nack_q <= 1'b0;
                    end
                end
                ST_START, ST_RSTART: begin
                    if (fire) begin
                        st      <= (st == ST_START) ? ST_CTRL : ST_RCTRL;
                        bit_cnt <= 4'd0;
                    end
                end
                ST_CTRL, ST_ADDR, ST_WDATA, ST_RCTRL: begin
                    if (fire) begin
                        if (bit_cnt == 4'd8) begin
                            wait_q <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end else if (ack_done) begin
                        wait_q  <= 1'b0;
                        bit_cnt <= 4'd0;
                        if (bit_bus.rbit) begin
                            nack_q <= 1'b1;   // no ack, abort with stop
                            st     <= ST_STOP;
                        end else begin
                            case (st)
                                ST_CTRL:  st <= ST_ADDR;
                                ST_ADDR:  st <= wr_q ? ST_WDATA : ST_RSTART;
                                ST_WDATA: st <= ST_STOP;
                                default:  st <= ST_RDATA;
                            endcase
                        end
                    end
                end
                ST_RDATA: begin
                    if (fire) begin
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'd7) begin
                            wait_q <= 1'b1;
                        end
                    end else if (ack_done) begin
                        wait_q <= 1'b0;
                        st     <= ST_MACK;
                    end
                end
                ST_MACK: begin
                    if (fire) begin
                        st <= ST_STOP;
                    end
                end
                ST_STOP: begin
                    if (fire) begin
                        wait_q <= 1'b1;
                    end else if (wait_q && bit_bus.cmd_ready) begin
                        wait_q    <= 1'b0;
                        rsp_valid <= 1'b1;
                        st        <= ST_IDLE;
                    end
                end
                default: st <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (st == ST_IDLE && req_valid) begin
            wr_q    <= req_write;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
        end
        if (st == ST_START && fire) begin
            shreg <= ctrl_byte(addr_q, 1'b0);
        end else if (st == ST_RSTART && fire) begin
            shreg <= ctrl_byte(addr_q, 1'b1);
        end else if (byte_state && fire && bit_cnt != 4'd8) begin
            shreg <= {shreg[6:0], 1'b0};
        end else if (byte_state && ack_done) begin
            shreg <= (st == ST_CTRL) ? addr_word(addr_q) : wdata_q;
        end else if (st == ST_RDATA && bit_bus.rbit_valid) begin
            shreg <= {shreg[6:0], bit_bus.rbit};
        end
        if (st == ST_RDATA && ack_done) begin
            rdata_q <= {shreg[6:0], bit_bus.rbit};  // last bit lands here
        end
    end

    a_req_idle: assert property (@(posedge CLK) disable iff (RESET)
        (req_valid && req_ready) |-> (bit_bus.cmd_ready && !bit_bus.rbit_valid));

    a_rsp_pulse: assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid |=> !rsp_valid);

endmodule

`default_nettype wire

/* hdl/eeprom_ctrl_top.sv */
`default_nettype none

module eeprom_ctrl_top #(
    parameter int SCL_DIV = 4     // CLK cycles per quarter SCL period
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic                  req_write,
    input  eeprom_pkg::mem_addr_t req_addr,
    input  eeprom_pkg::mem_data_t req_wdata,
    output logic                  rsp_valid,
    output eeprom_pkg::mem_data_t rsp_rdata,
    output logic                  rsp_nack,
    output logic                  scl,
    output logic                  sda_drive_low,   // open drain, pull-up outside
    input  logic                  sda_in
);

    i2c_bit_if bit_bus ();

    eeprom_sequencer sequencer_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .rsp_nack  (rsp_nack),
        .bit_bus   (bit_bus.seq)
    );

    i2c_bit_engine #(
        .SCL_DIV (SCL_DIV)
    ) bit_engine_inst (
        .CLK           (CLK),
        .RESET         (RESET),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in),
        .bit_bus       (bit_bus.eng)
    );

endmodule

`default_nettype wire

/* dv/eeprom_model.sv */
`default_nettype none

module eeprom_model (
    input  logic CLK,
    input  logic enable,          // low leaves every control byte unacknowledged
    input  logic scl,
    input  logic sda,
    output logic sda_drive_low
);

    import eeprom_pkg::*;

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_WORD,
        M_WDATA,
        M_DONE,    // byte stored, waiting for stop
        M_SEND
    } mode_t;

    mem_data_t  mem [0:2**ADDR_BITS-1];
    mode_t      mode;
    logic [3:0] cnt;           // SCL rises in this byte, ack slot included
    logic [7:0] shreg;
    block_t     block_q;
    word_addr_t word_q;
    logic       scl_q;
    logic       sda_q;

    initial begin
        for (int i = 0; i < 2**ADDR_BITS; i++) begin
            mem[i] = ~(i[7:0] ^ {i[10:8], 5'd0});   // erased cells, varied by address
        end
        mode          = M_IDLE;
        cnt           = 4'd0;
        sda_drive_low = 1'b0;
        scl_q         = 1'b1;
        sda_q         = 1'b1;
        word_q        = '0;
    end

    always @(posedge CLK) begin
        scl_q <= scl;
        sda_q <= sda;
        if (scl && scl_q && sda_q && !sda) begin
            mode          <= M_CTRL;    // start or repeated start
            cnt           <= 4'd0;
            sda_drive_low <= 1'b0;
        end else if (scl && scl_q && !sda_q && sda) begin
            mode          <= M_IDLE;    // stop
            sda_drive_low <= 1'b0;
        end else if (mode != M_IDLE && scl && !scl_q) begin
            cnt <= cnt + 4'd1;
            if (cnt < 4'd8 && mode != M_SEND) begin
                shreg <= {shreg[6:0], sda};
            end else if (cnt == 4'd8 && mode == M_SEND && sda) begin
                mode <= M_IDLE;         // master nack ends the read
            end
        end else if (mode != M_IDLE && !scl && scl_q) begin
            if (cnt == 4'd8) begin
                sda_drive_low <= 1'b0;
                case (mode)
                    M_CTRL: begin
                        if (enable && shreg[7:4] == DEVICE_CODE) begin
                            sda_drive_low <= 1'b1;
                            block_q       <= shreg[3:1];
                            mode          <= shreg[0] ? M_SEND : M_WORD;
                            shreg         <= mem[{shreg[3:1], word_q}];
                        end else begin
                            mode <= M_IDLE;
                        end
                    end
                    M_WORD: begin
                        sda_drive_low <= 1'b1;
                        word_q        <= shreg;
                        mode          <= M_WDATA;
                    end
                    M_WDATA: begin
                        sda_drive_low          <= 1'b1;
                        mem[{block_q, word_q}] <= shreg;
                        mode                   <= M_DONE;
                    end
                    default: ;
                endcase
            end else if (cnt == 4'd9) begin
                cnt           <= 4'd0;
                sda_drive_low <= (mode == M_SEND) && !shreg[7];   // first read bit
            end else if (mode == M_SEND) begin
                sda_drive_low <= !shreg[3'd7 - cnt[2:0]];
            end
        end
    end

endmodule

`default_nettype wire

/* dv/tb_eeprom_ctrl.sv */
`default_nettype none

module tb_eeprom_ctrl;

    import eeprom_pkg::*;

    localparam int          SCL_DIV    = 4;
    localparam int          N_TESTS    = 6;
    localparam int          N_TRANS    = 32;   // requests issued over the whole run
    localparam int          MAX_CYCLES = N_TRANS * 48 * 4 * SCL_DIV * 2;
    localparam int unsigned SEED       = 32'h7086_a958;

    logic      CLK;
    logic      RESET;
    logic      req_valid;
    logic      req_ready;
    logic      req_write;
    mem_addr_t req_addr;
    mem_data_t req_wdata;
    logic      rsp_valid;
    mem_data_t rsp_rdata;
    logic      rsp_nack;
    logic      scl;
    logic      dut_low;
    logic      model_low;
    logic      model_en;
    wire       sda = !(dut_low || model_low);   // open drain with pull-up

    mem_data_t shadow [0:2**ADDR_BITS-1];
    int        err_cnt;
    int        err_mark;
    int        fail_cnt;
    int        cycles;

    eeprom_ctrl_top #(
        .SCL_DIV (SCL_DIV)
    ) eeprom_ctrl_top_inst (
        .CLK           (CLK),
        .RESET         (RESET),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .rsp_valid     (rsp_valid),
        .rsp_rdata     (rsp_rdata),
        .rsp_nack      (rsp_nack),
        .scl           (scl),
        .sda_drive_low (dut_low),
        .sda_in        (sda)
    );

    eeprom_model eeprom_model_inst (
        .CLK           (CLK),
        .enable        (model_en),
        .scl           (scl),
        .sda           (sda),
        .sda_drive_low (model_low)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #50 CLK = ~CLK;
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // erased contents, same rule as the device
    function automatic mem_data_t fill_value(mem_addr_t a);
        return ~(a[7:0] ^ {a[10:8], 5'd0});
    endfunction

    task automatic next_cycle;
        @(posedge CLK);
        #10;
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name);
        if (err_cnt == err_mark) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed with %0d errors", name, err_cnt - err_mark);
            fail_cnt++;
        end
        err_mark = err_cnt;
    endtask

    task automatic issue_req(input logic wr, input mem_addr_t addr, input mem_data_t data);
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = data;
        while (!req_ready) begin
            next_cycle();
        end
        next_cycle();              // accepting edge
        req_valid = 1'b0;
    endtask

    task automatic wait_rsp(output logic nack, output mem_data_t rdata);
        while (!rsp_valid) begin
            next_cycle();
        end
        nack  = rsp_nack;
        rdata = rsp_rdata;
        next_cycle();
    endtask

    task automatic transact(input string name, input logic wr, input mem_addr_t addr,
                            input mem_data_t data);
        logic      nack;
        mem_data_t rdata;
        issue_req(wr, addr, data);
        wait_rsp(nack, rdata);
        check_val({name, " nack"}, 0, nack);
        if (wr) begin
            shadow[addr] = data;
        end else begin
            check_val({name, " rdata"}, shadow[addr], rdata);
        end
    endtask

    task automatic reset_state;
        check_val("reset_state req_ready", 1, req_ready);
        check_val("reset_state scl", 1, scl);
        check_val("reset_state sda_drive_low", 0, dut_low);
        check_val("reset_state rsp_valid", 0, rsp_valid);
        report_test("reset_state");
    endtask

    task automatic write_read_back;
        transact("write_read_back", 1'b1, 11'h123, 8'h5A);
        transact("write_read_back", 1'b0, 11'h123, 8'h00);
        report_test("write_read_back");
    endtask

    task automatic block_bits;
        transact("block_bits", 1'b1, 11'h000, 8'h11);
        transact("block_bits", 1'b1, 11'h400, 8'h22);
        transact("block_bits", 1'b1, 11'h7FF, 8'h33);
        transact("block_bits", 1'b0, 11'h000, 8'h00);
        transact("block_bits", 1'b0, 11'h400, 8'h00);
        transact("block_bits", 1'b0, 11'h7FF, 8'h00);
        report_test("block_bits");
    endtask

    task automatic missing_device;
        logic      nack;
        mem_data_t rdata;
        model_en = 1'b0;
        issue_req(1'b1, 11'h055, 8'hC3);
        wait_rsp(nack, rdata);
        check_val("missing_device write nack", 1, nack);
        issue_req(1'b0, 11'h055, 8'h00);
        wait_rsp(nack, rdata);
        check_val("missing_device read nack", 1, nack);
        check_val("missing_device req_ready", 1, req_ready);
        model_en = 1'b1;
        report_test("missing_device");
    endtask

    task automatic random_traffic;
        logic      wr;
        mem_addr_t addr;
        for (int i = 0; i < 20; i++) begin
            wr   = 1'($urandom);
            addr = {3'($urandom), 6'd0, 2'($urandom)};   // small set over all blocks
            transact("random_traffic", wr, addr, 8'($urandom));
        end
        report_test("random_traffic");
    endtask

    task automatic request_hold;
        int        seen;
        logic      done;
        logic      nack;
        mem_data_t rdata;
        seen = 0;
        done = 1'b0;
        issue_req(1'b1, 11'h2A7, 8'h96);
        shadow[11'h2A7] = 8'h96;
        req_valid = 1'b1;          // read waits behind the write in flight
        req_write = 1'b0;
        req_addr  = 11'h2A7;
        while (!done) begin
            if (rsp_valid) begin
                seen++;
                check_val("request_hold write nack", 0, rsp_nack);
            end
            if (req_ready) begin
                done = 1'b1;
            end else begin
                next_cycle();
            end
        end
        check_val("request_hold responses before accept", 1, seen);
        next_cycle();
        req_valid = 1'b0;
        wait_rsp(nack, rdata);
        check_val("request_hold read nack", 0, nack);
        check_val("request_hold read data", shadow[11'h2A7], rdata);
        report_test("request_hold");
    endtask

    initial begin
        RESET     = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        model_en  = 1'b1;
        void'($urandom(SEED));
        for (int i = 0; i < 2**ADDR_BITS; i++) begin
            shadow[i] = fill_value(mem_addr_t'(i));
        end
        repeat (3) begin
            @(posedge CLK);
        end
        #10;
        RESET = 1'b0;
        reset_state();
        write_read_back();
        block_bits();
        missing_device();
        random_traffic();
        request_hold();
        $display("%0d tests passed, %0d failed", N_TESTS - fail_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* eeprom_i2c.f */
hdl/i2c_pkg.sv
hdl/eeprom_pkg.sv
hdl/i2c_bit_if.sv
hdl/i2c_bit_engine.sv
hdl/eeprom_sequencer.sv
hdl/eeprom_ctrl_top.sv
dv/eeprom_model.sv
dv/tb_eeprom_ctrl.sv

/* Makefile */
TOP   = tb_eeprom_ctrl
FLIST = eeprom_i2c.f

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
